// ==== fp_format_pkg.sv ====
package fp_format_pkg;

   // single precision field layout
   localparam int EXP_W  = 8;
   localparam int FRAC_W = 23;

   localparam int BIAS    = 127;
   localparam int EXP_MAX = 255;  // all-ones exponent, inf or nan

   // canonical quiet nan, every nan result uses this pattern
   localparam logic [31:0] QNAN = 32'h7fc00000;

   // operand class, also used for results decided early in the pipe
   typedef enum logic [1:0] {
      ZERO   = 2'd0,
      NORMAL = 2'd1,  // arithmetic still pending
      INF    = 2'd2,
      NAN    = 2'd3
   } fp_class_e;

endpackage

// ==== fpu_ops_pkg.sv ====
package fpu_ops_pkg;

   // funct7 encodings
   typedef enum logic [6:0] {
      OP_ADD  = 7'b0000000,
      OP_SUB  = 7'b0000100,
      OP_MUL  = 7'b0001000,
      OP_NONE = 7'b1111111  // unknown code or bubble after reset
   } fpu_op_e;

   typedef enum logic [2:0] {
      RNE = 3'd0,  // nearest, ties to even
      RTZ = 3'd1,
      RDN = 3'd2,
      RUP = 3'd3,
      RMM = 3'd4   // nearest, ties away
   } round_mode_e;

   // flag word bit positions
   localparam int FLAG_NV = 4;
   localparam int FLAG_DZ = 3;
   localparam int FLAG_OF = 2;
   localparam int FLAG_UF = 1;
   localparam int FLAG_NX = 0;

endpackage

// ==== fpu_stage_if.sv ====
`timescale 1ns/1ps

// contents of one pipeline register between two stages
interface fpu_stage_if;
   import fp_format_pkg::*;
   import fpu_ops_pkg::*;

   fpu_op_e           op;
   round_mode_e       rm;
   fp_class_e         cls;     // NORMAL means not yet decided
   logic              sign;
   logic signed [9:0] exp;     // room for over and underflow
   logic [47:0]       mant_a;
   logic [26:0]       mant_b;
   logic              nv;      // invalid seen early

   modport src (
      output op, rm, cls, sign, exp, mant_a, mant_b, nv
   );

   modport dst (
      input op, rm, cls, sign, exp, mant_a, mant_b, nv
   );

endinterface

// ==== fpu_operand_stage.sv ====
`timescale 1ns/1ps

module fpu_operand_stage (
   input  logic        clk,
   input  logic        nrst,
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [6:0]  funct7,
   input  logic [2:0]  frm,
   fpu_stage_if.src    out
);
   import fp_format_pkg::*;
   import fpu_ops_pkg::*;

   fpu_op_e           op_d;
   round_mode_e       rm_d;
   fp_class_e         cls_a, cls_b, cls_d;
   logic              sign_bx;     // b sign after sub inversion
   logic              eff_sub;
   logic              a_big;
   logic [7:0]        ea, eb, e_big, e_diff;
   logic [23:0]       ma, mb, m_big, m_small;
   logic [5:0]        shamt;
   logic [53:0]       wide;
   logic [26:0]       aligned;
   logic              sticky;
   logic [47:0]       prod;
   logic              sign_d, nv_d;
   logic signed [9:0] exp_d;
   logic [47:0]       mant_a_d;
   logic [26:0]       mant_b_d;

   // subnormals fall into ZERO here
   function automatic fp_class_e classify(input logic [31:0] x);
      logic [7:0] e;
      e = x[FRAC_W +: EXP_W];
      if (e == '0)
         return ZERO;
      else if (e == EXP_MAX)
         return (x[FRAC_W-1:0] != '0) ? NAN : INF;
      else
         return NORMAL;
   endfunction

   always_comb begin
      case (funct7)
         OP_ADD:  op_d = OP_ADD;
         OP_SUB:  op_d = OP_SUB;
         OP_MUL:  op_d = OP_MUL;
         default: op_d = OP_NONE;
      endcase
      rm_d = (frm > 3'd4) ? RNE : round_mode_e'(frm);  // 5..7 act as rne
   end

   always_comb begin
      cls_a   = classify(a);
      cls_b   = classify(b);
      ea      = a[30:23];
      eb      = b[30:23];
      ma      = (cls_a == NORMAL) ? {1'b1, a[22:0]} : '0;  // flushed zero has no bits
      mb      = (cls_b == NORMAL) ? {1'b1, b[22:0]} : '0;
      sign_bx = b[31] ^ (op_d == OP_SUB);
      eff_sub = a[31] ^ sign_bx;

      // swap so the larger magnitude sits in m_big
      a_big   = {ea, ma} >= {eb, mb};
      e_big   = a_big ? ea : eb;
      e_diff  = a_big ? (ea - eb) : (eb - ea);
      m_big   = a_big ? ma : mb;
      m_small = a_big ? mb : ma;

      shamt   = (e_diff > 8'd27) ? 6'd27 : e_diff[5:0];
      wide    = {m_small, 3'b000, 27'b0} >> shamt;
      aligned = wide[53:27];
      sticky  = |wide[26:0];

      prod    = ma * mb;
   end

   // settle specials now or prepare the arithmetic
   always_comb begin
      cls_d    = ZERO;
      sign_d   = 1'b0;
      nv_d     = 1'b0;
      exp_d    = '0;
      mant_a_d = '0;
      mant_b_d = '0;
      case (op_d)
         OP_ADD, OP_SUB: begin
            if (cls_a == NAN || cls_b == NAN) begin
               cls_d = NAN;
            end else if (cls_a == INF && cls_b == INF && eff_sub) begin
               cls_d = NAN;  // inf minus inf
               nv_d  = 1'b1;
            end else if (cls_a == INF) begin
               cls_d  = INF;
               sign_d = a[31];
            end else if (cls_b == INF) begin
               cls_d  = INF;
               sign_d = sign_bx;
            end else if (cls_a == ZERO && cls_b == ZERO) begin
               sign_d = eff_sub ? (rm_d == RDN) : a[31];
            end else begin
               // one zero operand just aligns to nothing
               cls_d    = NORMAL;
               sign_d   = a_big ? a[31] : sign_bx;
               exp_d    = 10'(e_big);
               mant_a_d = {eff_sub, 20'b0, m_big, 3'b000};
               mant_b_d = {aligned[26:1], aligned[0] | sticky};
            end
         end
         OP_MUL: begin
            sign_d = a[31] ^ b[31];
            if (cls_a == NAN || cls_b == NAN) begin
               cls_d = NAN;
            end else if ((cls_a == ZERO && cls_b == INF) || (cls_a == INF && cls_b == ZERO)) begin
               cls_d = NAN;
               nv_d  = 1'b1;
            end else if (cls_a == INF || cls_b == INF) begin
               cls_d = INF;
            end else if (cls_a == NORMAL && cls_b == NORMAL) begin
               cls_d    = NORMAL;
               exp_d    = 10'(ea) + 10'(eb) - 10'(BIAS);
               mant_a_d = prod;
            end
         end
         default: ;  // bubble gives a zero result later
      endcase
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         out.op  <= OP_NONE;
         out.rm  <= RNE;
         out.cls <= ZERO;
         out.nv  <= 1'b0;
      end else begin
         out.op  <= op_d;
         out.rm  <= rm_d;
         out.cls <= cls_d;
         out.nv  <= nv_d;
      end
   end

   always_ff @(posedge clk) begin
      out.sign   <= sign_d;
      out.exp    <= exp_d;
      out.mant_a <= mant_a_d;
      out.mant_b <= mant_b_d;
   end

   // the combine stage subtracts small from big and needs big first
   a_swap_order: assert property (@(posedge clk) disable iff (!nrst)
      (out.cls == NORMAL && out.op != OP_MUL)
         |-> (out.mant_a[26] && out.mant_a[26:0] >= out.mant_b))
      else $error("stage 1 aligned operand exceeds the larger one");

endmodule

// ==== fpu_combine_stage.sv ====
`timescale 1ns/1ps

module fpu_combine_stage (
   input  logic     clk,
   input  logic     nrst,
   fpu_stage_if.dst in,
   fpu_stage_if.src out
);
   import fp_format_pkg::*;
   import fpu_ops_pkg::*;

   logic              eff_sub;
   logic [27:0]       sum;
   logic [4:0]        lz;
   logic [26:0]       norm;
   fp_class_e         cls_d;
   logic              sign_d;
   logic signed [9:0] exp_d;
   logic [25:0]       sig_d;  // 24 bits, round, sticky

   always_comb begin
      eff_sub = in.mant_a[47];
      if (eff_sub)
         sum = {1'b0, in.mant_a[26:0]} - {1'b0, in.mant_b};  // big minus small, never negative
      else
         sum = {1'b0, in.mant_a[26:0]} + {1'b0, in.mant_b};

      // highest set bit wins
      lz = 5'd0;
      for (int i = 0; i < 27; i++) begin
         if (sum[i])
            lz = 5'(26 - i);
      end
   end

   always_comb begin
      cls_d  = in.cls;
      sign_d = in.sign;
      exp_d  = in.exp;
      sig_d  = '0;
      norm   = '0;
      if (in.cls == NORMAL) begin
         if (in.op == OP_MUL) begin
            // product of two [1,2) values lies in [1,4)
            if (in.mant_a[47]) begin
               sig_d = {in.mant_a[47:24], in.mant_a[23], |in.mant_a[22:0]};
               exp_d = in.exp + 10'sd1;
            end else begin
               sig_d = {in.mant_a[46:23], in.mant_a[22], |in.mant_a[21:0]};
            end
         end else if (sum == '0) begin
            cls_d  = ZERO;  // exact cancellation
            sign_d = (in.rm == RDN);
         end else begin
            if (sum[27]) begin
               norm  = {sum[27:2], sum[1] | sum[0]};  // carry out, shift right
               exp_d = in.exp + 10'sd1;
            end else begin
               norm  = sum[26:0] << lz;
               exp_d = in.exp - 10'(lz);
            end
            sig_d = {norm[26:3], norm[2], |norm[1:0]};
         end
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         out.op  <= OP_NONE;
         out.rm  <= RNE;
         out.cls <= ZERO;
         out.nv  <= 1'b0;
      end else begin
         out.op  <= in.op;
         out.rm  <= in.rm;
         out.cls <= cls_d;
         out.nv  <= in.nv;
      end
   end

   always_ff @(posedge clk) begin
      out.sign   <= sign_d;
      out.exp    <= exp_d;
      out.mant_a <= {22'b0, sig_d};
      out.mant_b <= '0;  // unused past this stage
   end

   a_normalized: assert property (@(posedge clk) disable iff (!nrst)
      (out.cls == NORMAL) |-> out.mant_a[25])
      else $error("stage 2 significand not normalized");

endmodule

// ==== fpu_round_stage.sv ====
`timescale 1ns/1ps

module fpu_round_stage (
   fpu_stage_if.dst    in,
   output logic [31:0] result,
   output logic [4:0]  flags
);
   import fp_format_pkg::*;
   import fpu_ops_pkg::*;

   logic [23:0]       sig;
   logic              rnd, stk;
   logic              inexact;
   logic              inc;
   logic [24:0]       rounded;
   logic signed [9:0] exp_r;
   logic              max_finite;  // overflow saturates instead of inf

   always_comb begin
      sig     = in.mant_a[25:2];
      rnd     = in.mant_a[1];
      stk     = in.mant_a[0];
      inexact = rnd | stk;

      case (in.rm)
         RTZ:     inc = 1'b0;
         RDN:     inc = inexact & in.sign;
         RUP:     inc = inexact & ~in.sign;
         RMM:     inc = rnd;
         default: inc = rnd & (stk | sig[0]);  // ties to even
      endcase

      rounded = {1'b0, sig} + 25'(inc);
      exp_r   = in.exp + 10'(rounded[24]);  // a carry leaves the low bits zero

      max_finite = (in.rm == RTZ)
                || (in.rm == RDN && !in.sign)
                || (in.rm == RUP && in.sign);
   end

   always_comb begin
      result = '0;
      flags  = '0;
      if (in.op != OP_NONE) begin
         case (in.cls)
            NAN: begin
               result          = QNAN;
               flags[FLAG_NV]  = in.nv;
            end
            INF:  result = {in.sign, 8'hff, 23'b0};
            ZERO: result = {in.sign, 31'b0};
            default: begin
               if (exp_r >= EXP_MAX) begin
                  if (max_finite)
                     result = {in.sign, 8'hfe, 23'h7fffff};
                  else
                     result = {in.sign, 8'hff, 23'b0};
                  flags[FLAG_OF] = 1'b1;
                  flags[FLAG_NX] = 1'b1;
               end else if (exp_r < 1) begin
                  // flush to signed zero
                  result         = {in.sign, 31'b0};
                  flags[FLAG_UF] = 1'b1;
                  flags[FLAG_NX] = 1'b1;
               end else begin
                  result         = {in.sign, exp_r[7:0], rounded[22:0]};
                  flags[FLAG_NX] = inexact;
               end
            end
         endcase
      end
      flags[FLAG_DZ] = 1'b0;  // no divider in this unit
   end

   // invalid marker from stage 1 must never meet an overflow
   always_comb begin
      a_nv_of: assert (!(in.nv && flags[FLAG_OF]))
         else $error("invalid and overflow raised together");
   end

endmodule

// ==== fpu_top.sv ====
`timescale 1ns/1ps

module fpu_top (
   input  logic        clk,
   input  logic        nrst,
   input  logic [31:0] floating_point1,
   input  logic [31:0] floating_point2,
   input  logic [6:0]  funct7,
   input  logic [2:0]  frm,
   output logic [31:0] floating_point_out,
   output logic [4:0]  flags
);

   fpu_stage_if s1 ();  // operand -> combine
   fpu_stage_if s2 ();  // combine -> round

   fpu_operand_stage u_operand (
      .clk    (clk),
      .nrst   (nrst),
      .a      (floating_point1),
      .b      (floating_point2),
      .funct7 (funct7),
      .frm    (frm),
      .out    (s1)
   );

   fpu_combine_stage u_combine (
      .clk  (clk),
      .nrst (nrst),
      .in   (s1),
      .out  (s2)
   );

   // combinational, result follows the second register
   fpu_round_stage u_round (
      .in     (s2),
      .result (floating_point_out),
      .flags  (flags)
   );

endmodule

// ==== tb_fpu_model.svh ====
`ifndef TB_FPU_MODEL_SVH
`define TB_FPU_MODEL_SVH

localparam logic [31:0] CANON_NAN = 32'h7fc00000;

// significand placed 50 bits up, minus the exponent gap; far below it only counts as sticky
function automatic logic [127:0] place_sig(input logic [22:0] frac, input int d);
   if (d > 50)
      return 128'd1;
   return 128'({1'b1, frac}) << (50 - d);
endfunction

// sign * mag * 2**scale to single precision, returns {flags, bits}
function automatic logic [36:0] round_to_single(input logic sign, input logic [127:0] mag,
                                                input int scale, input int rm);
   int           msb;
   int           e;
   int           sh;
   logic [127:0] kept;
   logic [127:0] rem;
   logic [127:0] half;
   logic         up;
   logic         maxf;
   msb = 0;
   for (int i = 0; i < 128; i++)
      if (mag[i])
         msb = i;
   e  = msb + scale + 127;
   sh = msb - 23;
   if (sh > 0) begin
      kept = mag >> sh;
      rem  = mag & ((128'd1 << sh) - 128'd1);
      half = 128'd1 << (sh - 1);
   end else begin
      kept = mag << (-sh);  // exact, nothing dropped
      rem  = '0;
      half = '0;
   end
   case (rm)
      1:       up = 1'b0;
      2:       up = (rem != '0) && sign;
      3:       up = (rem != '0) && !sign;
      4:       up = (sh > 0) && (rem >= half);
      default: up = (sh > 0) && ((rem > half) || (rem == half && kept[0]));
   endcase
   kept = kept + 128'(up);
   if (kept[24]) begin
      kept = kept >> 1;
      e    = e + 1;
   end
   maxf = (rm == 1) || (rm == 2 && !sign) || (rm == 3 && sign);
   if (e >= 255)
      return {5'b00101, maxf ? {sign, 8'hfe, 23'h7fffff} : {sign, 8'hff, 23'h0}};
   if (e < 1)
      return {5'b00011, sign, 31'b0};  // flushed
   return {4'b0, rem != '0, sign, e[7:0], kept[22:0]};
endfunction

function automatic logic [36:0] fpu_model(input logic [31:0] a, input logic [31:0] b,
                                          input logic [6:0] funct7, input logic [2:0] frm);
   int           rm;
   int           ea, eb, emax;
   logic         sa, sb;
   logic         za, zb, ia, ib, na, nb;
   logic [127:0] wa, wb, mag;
   logic         sign;
   rm = (frm > 3'd4) ? 0 : int'(frm);
   ea = int'(a[30:23]);
   eb = int'(b[30:23]);
   za = (ea == 0);  // subnormals count as zero
   zb = (eb == 0);
   ia = (ea == 255) && (a[22:0] == '0);
   ib = (eb == 255) && (b[22:0] == '0);
   na = (ea == 255) && (a[22:0] != '0);
   nb = (eb == 255) && (b[22:0] != '0);
   if (funct7 == 7'b0001000) begin
      if (na || nb)
         return {5'b0, CANON_NAN};
      if ((za && ib) || (ia && zb))
         return {5'b10000, CANON_NAN};
      if (ia || ib)
         return {5'b0, a[31] ^ b[31], 8'hff, 23'b0};
      if (za || zb)
         return {5'b0, a[31] ^ b[31], 31'b0};
      mag = 128'({1'b1, a[22:0]}) * 128'({1'b1, b[22:0]});
      return round_to_single(a[31] ^ b[31], mag, ea + eb - 300, rm);
   end
   if (funct7 != 7'b0000000 && funct7 != 7'b0000100)
      return 37'd0;
   sa = a[31];
   sb = b[31] ^ (funct7 == 7'b0000100);  // sub flips b
   if (na || nb)
      return {5'b0, CANON_NAN};
   if (ia && ib)
      return (sa != sb) ? {5'b10000, CANON_NAN} : {5'b0, sa, 8'hff, 23'b0};
   if (ia || ib)
      return {5'b0, ia ? sa : sb, 8'hff, 23'b0};
   if (za && zb)
      return {5'b0, (sa == sb) ? sa : (rm == 2), 31'b0};
   emax = (ea > eb) ? ea : eb;
   wa   = za ? '0 : place_sig(a[22:0], emax - ea);
   wb   = zb ? '0 : place_sig(b[22:0], emax - eb);
   if (sa == sb) begin
      mag  = wa + wb;
      sign = sa;
   end else if (wa > wb) begin
      mag  = wa - wb;
      sign = sa;
   end else if (wb > wa) begin
      mag  = wb - wa;
      sign = sb;
   end else begin
      return {5'b0, rm == 2, 31'b0};  // exact cancellation
   end
   return round_to_single(sign, mag, emax - 200, rm);
endfunction

`endif

// ==== tb_fpu.sv ====
`timescale 1ns/1ps

module tb_fpu;
   `include "tb_fpu_model.svh"

   localparam int N_IDLE  = 6;
   localparam int N_ADD   = 400;
   localparam int N_MUL   = 300;
   localparam int N_SPEC  = 200;
   localparam int N_RANGE = 200;
   localparam int N_MIX   = 300;
   localparam int N_FLUSH = 3;
   localparam int TOTAL_CYC = 3 + N_IDLE + N_ADD + N_MUL + N_SPEC + N_RANGE + N_MIX
                            + 6 * N_FLUSH;

   // zeros, infinities, nans, subnormals and a few plain values
   localparam logic [31:0] SPECIALS [10] = '{
      32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000, 32'h7fc00000,
      32'h7f800001, 32'h00000123, 32'h80400000, 32'h3f800000, 32'hc0200000
   };

   logic        clk = 1'b0;
   logic        nrst = 1'b0;
   logic [31:0] fp1 = '0;
   logic [31:0] fp2 = '0;
   logic [6:0]  funct7 = 7'h7f;
   logic [2:0]  frm = '0;
   logic [31:0] fp_out;
   logic [4:0]  flags;

   logic [73:0] hist0, hist1;  // {a, b, funct7, frm}
   logic        vld0, vld1;
   logic        armed = 1'b0;
   logic [36:0] expect_vec;
   logic [31:0] rng_state = 32'h14fa66f8;
   int          checks = 0;
   int          errors = 0;

   always #20 clk = ~clk;

   fpu_top dut0 (
      .clk                (clk),
      .nrst               (nrst),
      .floating_point1    (fp1),
      .floating_point2    (fp2),
      .funct7             (funct7),
      .frm                (frm),
      .floating_point_out (fp_out),
      .flags              (flags)
   );

   always @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         vld0 <= 1'b0;
         vld1 <= 1'b0;
      end else begin
         vld0 <= 1'b1;  // an operation was sampled at this edge
         vld1 <= vld0;
      end
   end

   always @(posedge clk) begin
      hist0 <= {fp1, fp2, funct7, frm};
      hist1 <= hist0;
      armed <= 1'b1;  // first edge clears the pipe
      if (vld1)
         checks++;
   end

   always_comb expect_vec = fpu_model(hist1[73:42], hist1[41:10], hist1[9:3], hist1[2:0]);

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp_v, act_v);
   endtask

   a_result: assert property (@(posedge clk) vld1 |-> fp_out == expect_vec[31:0])
      else report_mismatch("floating_point_out", $sampled(expect_vec[31:0]), $sampled(fp_out));
   a_flags: assert property (@(posedge clk) vld1 |-> flags == expect_vec[36:32])
      else report_mismatch("flags", {27'd0, $sampled(expect_vec[36:32])},
                           {27'd0, $sampled(flags)});
   a_idle_out: assert property (@(posedge clk) (armed && !vld1) |-> fp_out == '0)
      else report_mismatch("floating_point_out", 32'd0, $sampled(fp_out));
   a_idle_flags: assert property (@(posedge clk) (armed && !vld1) |-> flags == '0)
      else report_mismatch("flags", 32'd0, {27'd0, $sampled(flags)});

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // random sign and fraction, biased exponent in [e_lo, e_lo + e_span)
   function automatic logic [31:0] rand_normal(input int e_lo, input int e_span);
      logic [31:0] r;
      logic [31:0] f;
      r = rand32();
      f = rand32();
      return {r[0], 8'(e_lo + int'(r[31:24]) % e_span), f[22:0]};
   endfunction

   function automatic logic [6:0] pick_op(input logic [1:0] s);
      case (s)
         2'd0:    return 7'b0000000;
         2'd1:    return 7'b0000100;
         2'd2:    return 7'b0001000;
         default: return 7'b0110011;  // unsupported code
      endcase
   endfunction

   task automatic drive(input logic [31:0] a, input logic [31:0] b, input logic [6:0] f,
                        input logic [2:0] rm);
      @(negedge clk);
      fp1    = a;
      fp2    = b;
      funct7 = f;
      frm    = rm;
   endtask

   // lets the last operations leave the pipe, then reports
   task automatic end_test(input string name, input int c0, input int e0);
      repeat (N_FLUSH) drive(32'd0, 32'd0, 7'h7f, 3'd0);
      $display("%-8s %0d checks, %0d errors", name, checks - c0, errors - e0);
   endtask

   initial begin : watchdog
      #((TOTAL_CYC + 20) * 40);
      $display("timeout: the run did not finish in the expected time");
      $display("tests failed");
      $finish;
   end

   initial begin
      logic [31:0] x, y, r;
      int          c0, e0;
      c0 = checks;
      e0 = errors;
      repeat (3) drive(rand32(), rand32(), 7'b0101010, 3'd0);
      nrst = 1'b1;  // released on the last reset falling edge
      repeat (N_IDLE) drive(rand32(), rand32(), 7'b1000001, 3'd0);
      end_test("reset", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int i = 0; i < N_ADD; i++) begin
         x = rand_normal(120, 16);
         y = rand_normal(120, 16);
         r = rand32();
         if (r[5:4] == 2'b00)
            y = x;  // cancels under sub
         else if (r[5:4] == 2'b01)
            y = {~x[31], x[30:0]};  // cancels under add
         else if (r[5:4] == 2'b10)
            y = {x[31:8], r[31:24]};
         drive(x, y, r[6] ? 7'b0000100 : 7'b0000000, r[2:0]);
      end
      end_test("add_sub", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int i = 0; i < N_MUL; i++) begin
         x = rand_normal(100, 55);
         y = rand_normal(100, 55);
         r = rand32();
         if (r[4]) begin
            x[15:0] = '0;  // short fractions, exact product
            y[15:0] = '0;
         end
         drive(x, y, 7'b0001000, r[2:0]);
      end
      end_test("mul", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int i = 0; i < N_SPEC; i++) begin
         r = rand32();
         x = SPECIALS[int'(r[7:4]) % 10];
         y = r[8] ? SPECIALS[int'(r[15:12]) % 10] : rand_normal(110, 30);
         if (r[9])
            drive(y, x, pick_op(r[11:10]), r[2:0]);
         else
            drive(x, y, pick_op(r[11:10]), r[2:0]);
      end
      end_test("specials", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int i = 0; i < N_RANGE; i++) begin
         r = rand32();
         if (r[10]) begin
            x = r[8] ? rand_normal(225, 30) : rand_normal(1, 30);
            y = r[9] ? rand_normal(225, 30) : rand_normal(1, 30);
            drive(x, y, 7'b0001000, r[2:0]);
         end else begin
            x = rand_normal(252, 3);
            y = rand_normal(252, 3);
            y[31] = x[31] ^ r[11];  // same effective sign, sum grows
            drive(x, y, r[11] ? 7'b0000100 : 7'b0000000, r[2:0]);
         end
      end
      end_test("range", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int i = 0; i < N_MIX; i++) begin
         r = rand32();
         x = r[8] ? SPECIALS[int'(r[7:4]) % 10] : rand_normal(60, 140);
         y = r[9] ? SPECIALS[int'(r[15:12]) % 10] : rand_normal(60, 140);
         drive(x, y, pick_op(r[11:10]), r[2:0]);
      end
      end_test("mixed", c0, e0);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+.
fp_format_pkg.sv
fpu_ops_pkg.sv
fpu_stage_if.sv
fpu_operand_stage.sv
fpu_combine_stage.sv
fpu_round_stage.sv
fpu_top.sv
tb_fpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_fpu

sim_out=$(./obj_dir/Vtb_fpu 2>&1) || true
echo "$sim_out"

if grep -qx "all tests passed" <<< "$sim_out"; then
   exit 0
fi
exit 1
